// ==== hdl/valu_consts.svh ====
`ifndef VALU_CONSTS_SVH
`define VALU_CONSTS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// One vector register
`define VLEN_BITS 128

// One lane slice of a register
`define LANE_BITS 32

////////////////////////////////////////////////////////////
// Lane array shape
////////////////////////////////////////////////////////////

// Lanes that together cover one vector register
`define LANES_PER_GROUP 4

// Lane groups, also the largest register group (LMUL 4)
`define NUM_GROUPS 4

////////////////////////////////////////////////////////////
// Highest legal code of each instruction field
////////////////////////////////////////////////////////////

`define SEW_CODE_MAX 2
`define LMUL_CODE_MAX 2
`define LANES_CODE_MAX 2
`define OP_CODE_MAX 11

`endif

// ==== hdl/valu_pkg.sv ====
package valu_pkg;

    `include "valu_consts.svh"

    // Register and lane slices
    typedef logic [`VLEN_BITS-1:0] vreg_t;
    typedef logic [`LANE_BITS-1:0] lane_word_t;

    // 0: 8 bit, 1: 16 bit, 2: 32 bit
    typedef logic [2:0] sew_code_t;

    // 0: one register, 1: two, 2: four
    typedef logic [1:0] lmul_code_t;

    // 0: 4 lanes, 1: 8 lanes, 2: 16 lanes
    typedef logic [1:0] lanes_code_t;

    // Pass counter of the sequencer
    typedef logic [1:0] pass_idx_t;

    // Codes 12 to 15 are left unused
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_MIN  = 4'd8,
        OP_MAX  = 4'd9,
        OP_MUL  = 4'd10,
        OP_MULH = 4'd11
    } vop_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } seq_state_e;

endpackage

// ==== hdl/v_alu.sv ====
`timescale 1ns/1ps

module v_alu import valu_pkg::*; (
    input  logic       valu_clk,
    input  logic       arst_n,
    input  logic       en,
    input  vop_e       op,
    input  sew_code_t  sew,
    input  lane_word_t a,
    input  lane_word_t b,
    output lane_word_t result
);

    lane_word_t r8, r16, r32;
    lane_word_t nxt;

    // Operands arrive sign and zero extended to 32 bits,
    // only the low SEW bits of the return value are kept
    function automatic lane_word_t elem_calc(vop_e f, lane_word_t xs, lane_word_t xz,
                                             lane_word_t ys, logic [4:0] sh);
        lane_word_t r;
        case (f)
            OP_ADD:  r = xs + ys;
            OP_SUB:  r = xs - ys;
            OP_AND:  r = xs & ys;
            OP_OR:   r = xs | ys;
            OP_XOR:  r = xs ^ ys;
            OP_SLL:  r = xs << sh;
            OP_SRL:  r = xz >> sh;
            OP_SRA:  r = $signed(xs) >>> sh;
            OP_MIN:  r = ($signed(xs) < $signed(ys)) ? xs : ys;
            OP_MAX:  r = ($signed(xs) > $signed(ys)) ? xs : ys;
            default: r = '0;
        endcase
        return r;
    endfunction

    always_comb begin
        lane_word_t t;
        r8  = '0;
        r16 = '0;
        // Four bytes, shift amount from 3 bits
        for (int i = 0; i < 4; i++) begin
            t = elem_calc(op, {{24{a[8*i+7]}}, a[8*i +: 8]}, {24'd0, a[8*i +: 8]},
                          {{24{b[8*i+7]}}, b[8*i +: 8]}, {2'b00, b[8*i +: 3]});
            r8[8*i +: 8] = t[7:0];
        end
        // Two halfwords, shift amount from 4 bits
        for (int i = 0; i < 2; i++) begin
            t = elem_calc(op, {{16{a[16*i+15]}}, a[16*i +: 16]}, {16'd0, a[16*i +: 16]},
                          {{16{b[16*i+15]}}, b[16*i +: 16]}, {1'b0, b[16*i +: 4]});
            r16[16*i +: 16] = t[15:0];
        end
        r32 = elem_calc(op, a, a, b, b[4:0]);
    end

    always_comb begin
        case (sew)
            3'd0:    nxt = r8;
            3'd1:    nxt = r16;
            default: nxt = r32;
        endcase
    end

    // Lane result register, loads only on an active ALU pass
    always_ff @(posedge valu_clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (en) begin
            result <= nxt;
        end
    end

endmodule

// ==== hdl/v_mul.sv ====
`timescale 1ns/1ps

module v_mul import valu_pkg::*; (
    input  logic       valu_clk,
    input  logic       arst_n,
    input  logic       en,
    input  logic       high,
    input  sew_code_t  sew,
    input  lane_word_t a,
    input  lane_word_t b,
    output lane_word_t result
);

    lane_word_t r8, r16, r32;
    lane_word_t nxt;

    ////////////////////////////////////////////////////////////
    // Signed double-width products per element
    ////////////////////////////////////////////////////////////

    always_comb begin
        logic signed [15:0] p8;
        logic signed [31:0] p16;
        logic signed [63:0] p32;
        r8  = '0;
        r16 = '0;
        for (int i = 0; i < 4; i++) begin
            p8 = $signed(a[8*i +: 8]) * $signed(b[8*i +: 8]);
            r8[8*i +: 8] = high ? p8[15:8] : p8[7:0];
        end
        for (int i = 0; i < 2; i++) begin
            p16 = $signed(a[16*i +: 16]) * $signed(b[16*i +: 16]);
            r16[16*i +: 16] = high ? p16[31:16] : p16[15:0];
        end
        p32 = $signed(a) * $signed(b);
        r32 = high ? p32[63:32] : p32[31:0];
    end

    always_comb begin
        case (sew)
            3'd0:    nxt = r8;
            3'd1:    nxt = r16;
            default: nxt = r32;
        endcase
    end

    always_ff @(posedge valu_clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (en) begin
            result <= nxt;
        end
    end

endmodule

// ==== hdl/v_issue.sv ====
`timescale 1ns/1ps

`include "valu_consts.svh"

module v_issue import valu_pkg::*; (
    input  logic        valu_clk,
    input  logic        arst_n,
    input  logic        start,
    input  vop_e        op,
    input  sew_code_t   sew,
    input  lmul_code_t  lmul,
    input  lanes_code_t lanes,
    input  vreg_t       op_a_1,
    input  vreg_t       op_a_2,
    input  vreg_t       op_a_3,
    input  vreg_t       op_a_4,
    input  vreg_t       op_b_1,
    input  vreg_t       op_b_2,
    input  vreg_t       op_b_3,
    input  vreg_t       op_b_4,
    input  logic        fin,
    output logic        go,
    output logic        err,
    output logic        busy,
    output vop_e        cur_op,
    output sew_code_t   cur_sew,
    output lmul_code_t  cur_lmul,
    output lanes_code_t cur_lanes,
    output vreg_t       src_a_1,
    output vreg_t       src_a_2,
    output vreg_t       src_a_3,
    output vreg_t       src_a_4,
    output vreg_t       src_b_1,
    output vreg_t       src_b_2,
    output vreg_t       src_b_3,
    output vreg_t       src_b_4
);

    logic legal;
    logic accept;

    // All four fields must hold a defined code
    assign legal = (sew <= sew_code_t'(`SEW_CODE_MAX)) &&
                   (lmul <= lmul_code_t'(`LMUL_CODE_MAX)) &&
                   (lanes <= lanes_code_t'(`LANES_CODE_MAX)) &&
                   (4'(op) <= 4'(`OP_CODE_MAX));

    // A start while busy is dropped silently
    assign accept = start && !busy && legal;

    always_ff @(posedge valu_clk or negedge arst_n) begin
        if (!arst_n) begin
            go        <= 1'b0;
            err       <= 1'b0;
            busy      <= 1'b0;
            cur_op    <= OP_ADD;
            cur_sew   <= '0;
            cur_lmul  <= '0;
            cur_lanes <= '0;
        end else begin
            go  <= accept;
            err <= start && !busy && !legal;
            if (fin) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy <= 1'b1;
            end
            if (accept) begin
                cur_op    <= op;
                cur_sew   <= sew;
                cur_lmul  <= lmul;
                cur_lanes <= lanes;
            end
        end
    end

    // Source operand latches
    always_ff @(posedge valu_clk) begin
        if (accept) begin
            src_a_1 <= op_a_1;
            src_a_2 <= op_a_2;
            src_a_3 <= op_a_3;
            src_a_4 <= op_a_4;
            src_b_1 <= op_b_1;
            src_b_2 <= op_b_2;
            src_b_3 <= op_b_3;
            src_b_4 <= op_b_4;
        end
    end

endmodule

// ==== hdl/v_lanes.sv ====
`timescale 1ns/1ps

`include "valu_consts.svh"

module v_lanes import valu_pkg::*; (
    input  logic        valu_clk,
    input  logic        arst_n,
    input  logic        go,
    input  vop_e        cur_op,
    input  sew_code_t   cur_sew,
    input  lmul_code_t  cur_lmul,
    input  lanes_code_t cur_lanes,
    input  vreg_t       src_a_1,
    input  vreg_t       src_a_2,
    input  vreg_t       src_a_3,
    input  vreg_t       src_a_4,
    input  vreg_t       src_b_1,
    input  vreg_t       src_b_2,
    input  vreg_t       src_b_3,
    input  vreg_t       src_b_4,
    output vreg_t       res_1,
    output vreg_t       res_2,
    output vreg_t       res_3,
    output vreg_t       res_4,
    output logic        done,
    output logic        fin
);

    seq_state_e state;
    pass_idx_t  pass, last_pass, wb_pass;
    logic       wb_valid, done_q;
    logic       is_mul, mul_high;
    vreg_t      src_a [`NUM_GROUPS];
    vreg_t      src_b [`NUM_GROUPS];
    vreg_t      steer_a [`NUM_GROUPS];
    vreg_t      steer_b [`NUM_GROUPS];
    vreg_t      grp_res [`NUM_GROUPS];
    vreg_t      res_q [`NUM_GROUPS];
    logic [3:0] run_idx [`NUM_GROUPS];
    logic [3:0] wb_idx [`NUM_GROUPS];
    logic [`NUM_GROUPS-1:0] grp_en, wb_act;
    lane_word_t alu_lane [`NUM_GROUPS][`LANES_PER_GROUP];
    lane_word_t mul_lane [`NUM_GROUPS][`LANES_PER_GROUP];

    // Register worked on by group g in pass p
    function automatic logic [3:0] reg_index(pass_idx_t p, lanes_code_t ln, int unsigned g);
        return 4'(({2'b00, p} << ln) + g);
    endfunction

    // Group must be enabled and its register inside the group count
    function automatic logic grp_used(logic [3:0] idx, int unsigned g,
                                      lanes_code_t ln, lmul_code_t lm);
        return (g < (1 << ln)) && (idx < (4'd1 << lm));
    endfunction

    assign src_a = '{src_a_1, src_a_2, src_a_3, src_a_4};
    assign src_b = '{src_b_1, src_b_2, src_b_3, src_b_4};

    assign is_mul   = (cur_op == OP_MUL) || (cur_op == OP_MULH);
    assign mul_high = (cur_op == OP_MULH);

    // P minus one, with P = R / G and at least one pass
    assign last_pass = (cur_lmul > cur_lanes) ?
                       pass_idx_t'((3'd1 << (cur_lmul - cur_lanes)) - 3'd1) : '0;

    ////////////////////////////////////////////////////////////
    // Pass sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge valu_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            pass     <= '0;
            wb_valid <= 1'b0;
            wb_pass  <= '0;
            done_q   <= 1'b0;
        end else begin
            // Lane registers hold the pass steered in the previous cycle
            wb_valid <= (state == RUN);
            wb_pass  <= pass;
            done_q   <= (state == DRAIN);
            case (state)
                IDLE: begin
                    pass <= '0;
                    if (go) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (pass == last_pass) begin
                        state <= DRAIN;
                    end else begin
                        pass <= pass + 2'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Operand steering and lane array
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int g = 0; g < `NUM_GROUPS; g++) begin
            run_idx[g] = reg_index(pass, cur_lanes, g);
            wb_idx[g]  = reg_index(wb_pass, cur_lanes, g);
            grp_en[g]  = (state == RUN) && grp_used(run_idx[g], g, cur_lanes, cur_lmul);
            wb_act[g]  = wb_valid && grp_used(wb_idx[g], g, cur_lanes, cur_lmul);
            steer_a[g] = grp_en[g] ? src_a[run_idx[g][1:0]] : '0;
            steer_b[g] = grp_en[g] ? src_b[run_idx[g][1:0]] : '0;
            for (int l = 0; l < `LANES_PER_GROUP; l++) begin
                grp_res[g][l*`LANE_BITS +: `LANE_BITS] = is_mul ? mul_lane[g][l] : alu_lane[g][l];
            end
        end
    end

    for (genvar g = 0; g < `NUM_GROUPS; g++) begin : g_grp
        for (genvar l = 0; l < `LANES_PER_GROUP; l++) begin : g_lane
            v_alu u_alu (
                .valu_clk (valu_clk),
                .arst_n   (arst_n),
                .en       (grp_en[g] && !is_mul),
                .op       (cur_op),
                .sew      (cur_sew),
                .a        (steer_a[g][l*`LANE_BITS +: `LANE_BITS]),
                .b        (steer_b[g][l*`LANE_BITS +: `LANE_BITS]),
                .result   (alu_lane[g][l])
            );
            v_mul u_mul (
                .valu_clk (valu_clk),
                .arst_n   (arst_n),
                .en       (grp_en[g] && is_mul),
                .high     (mul_high),
                .sew      (cur_sew),
                .a        (steer_a[g][l*`LANE_BITS +: `LANE_BITS]),
                .b        (steer_b[g][l*`LANE_BITS +: `LANE_BITS]),
                .result   (mul_lane[g][l])
            );
        end
    end

    // Destination registers, unused ones cleared at go
    always_ff @(posedge valu_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < `NUM_GROUPS; k++) begin
                res_q[k] <= '0;
            end
        end else if (go) begin
            for (int k = 0; k < `NUM_GROUPS; k++) begin
                if (k >= (1 << cur_lmul)) begin
                    res_q[k] <= '0;
                end
            end
        end else begin
            for (int g = 0; g < `NUM_GROUPS; g++) begin
                if (wb_act[g]) begin
                    res_q[wb_idx[g][1:0]] <= grp_res[g];
                end
            end
        end
    end

    assign res_1 = res_q[0];
    assign res_2 = res_q[1];
    assign res_3 = res_q[2];
    assign res_4 = res_q[3];
    assign done  = done_q;
    assign fin   = done_q;

endmodule

// ==== hdl/v_unit.sv ====
`timescale 1ns/1ps

module v_unit import valu_pkg::*; (
    input  logic        valu_clk,
    input  logic        arst_n,
    input  logic        start,
    input  vop_e        op,
    input  sew_code_t   sew,
    input  lmul_code_t  lmul,
    input  lanes_code_t lanes,
    input  vreg_t       op_a_1,
    input  vreg_t       op_a_2,
    input  vreg_t       op_a_3,
    input  vreg_t       op_a_4,
    input  vreg_t       op_b_1,
    input  vreg_t       op_b_2,
    input  vreg_t       op_b_3,
    input  vreg_t       op_b_4,
    output vreg_t       res_1,
    output vreg_t       res_2,
    output vreg_t       res_3,
    output vreg_t       res_4,
    output logic        busy,
    output logic        done,
    output logic        err
);

    logic        go, fin;
    vop_e        cur_op;
    sew_code_t   cur_sew;
    lmul_code_t  cur_lmul;
    lanes_code_t cur_lanes;
    vreg_t       src_a_1, src_a_2, src_a_3, src_a_4;
    vreg_t       src_b_1, src_b_2, src_b_3, src_b_4;

    // Instruction capture and code check
    v_issue i_issue (
        .valu_clk, .arst_n, .start, .op, .sew, .lmul, .lanes,
        .op_a_1, .op_a_2, .op_a_3, .op_a_4,
        .op_b_1, .op_b_2, .op_b_3, .op_b_4,
        .fin, .go, .err, .busy,
        .cur_op, .cur_sew, .cur_lmul, .cur_lanes,
        .src_a_1, .src_a_2, .src_a_3, .src_a_4,
        .src_b_1, .src_b_2, .src_b_3, .src_b_4
    );

    // Lane array and pass sequencer
    v_lanes i_lanes (
        .valu_clk, .arst_n, .go,
        .cur_op, .cur_sew, .cur_lmul, .cur_lanes,
        .src_a_1, .src_a_2, .src_a_3, .src_a_4,
        .src_b_1, .src_b_2, .src_b_3, .src_b_4,
        .res_1, .res_2, .res_3, .res_4,
        .done, .fin
    );

endmodule

// ==== tb/tb_v_unit_model.svh ====
`ifndef TB_V_UNIT_MODEL_SVH
`define TB_V_UNIT_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference model of the vector unit
////////////////////////////////////////////////////////////

// One element of width w, x and y are the raw unsigned fields
function automatic logic [31:0] elem_ref(input vop_e f, input int w,
                                         input longint x, input longint y);
    longint mask;
    longint sbit;
    longint sx;
    longint sy;
    longint sh;
    longint r;
    mask = (longint'(1) << w) - 1;
    sbit = longint'(1) << (w - 1);
    // Two's complement value of each field
    sx = (x ^ sbit) - sbit;
    sy = (y ^ sbit) - sbit;
    sh = y % w;
    case (f)
        OP_ADD:  r = x + y;
        OP_SUB:  r = x - y;
        OP_AND:  r = x & y;
        OP_OR:   r = x | y;
        OP_XOR:  r = x ^ y;
        OP_SLL:  r = x << sh;
        OP_SRL:  r = x >> sh;
        OP_SRA:  r = sx >>> sh;
        OP_MIN:  r = (sx < sy) ? x : y;
        OP_MAX:  r = (sx > sy) ? x : y;
        OP_MUL:  r = sx * sy;
        OP_MULH: r = (sx * sy) >>> w;
        default: r = 0;
    endcase
    return 32'(r & mask);
endfunction

// Whole register, element by element
function automatic vreg_t reg_ref(input vop_e f, input sew_code_t s,
                                  input vreg_t a, input vreg_t b);
    int     w;
    longint mask;
    longint x;
    longint y;
    vreg_t  r;
    w    = 8 << s;
    mask = (longint'(1) << w) - 1;
    r    = '0;
    for (int e = 0; e < `VLEN_BITS / w; e++) begin
        x = longint'(a >> (e * w)) & mask;
        y = longint'(b >> (e * w)) & mask;
        r = r | (vreg_t'(elem_ref(f, w, x, y)) << (e * w));
    end
    return r;
endfunction

// Destination register k, zero outside the register group
function automatic vreg_t expected_reg(input int k, input vop_e f, input sew_code_t s,
                                       input lmul_code_t m, input vreg_t a, input vreg_t b);
    if (k >= (1 << m)) begin
        return '0;
    end
    return reg_ref(f, s, a, b);
endfunction

// Passes P = R / G, at least one
function automatic int pass_count(input lmul_code_t m, input lanes_code_t n);
    int regs;
    int groups;
    regs   = 1 << m;
    groups = 1 << n;
    return (regs > groups) ? regs / groups : 1;
endfunction

`endif

// ==== tb/tb_v_unit.sv ====
`timescale 1ns/1ps

`include "valu_consts.svh"

module tb_v_unit import valu_pkg::*; ();

    logic        valu_clk;
    logic        arst_n;
    logic        start;
    vop_e        op;
    sew_code_t   sew;
    lmul_code_t  lmul;
    lanes_code_t lanes;
    logic        busy, done, err;
    vreg_t       a_in [`NUM_GROUPS];
    vreg_t       b_in [`NUM_GROUPS];
    vreg_t       res_w [`NUM_GROUPS];
    vreg_t       exp_res [`NUM_GROUPS];
    int          checks, errors;

    // Operand kind per case (0 random, 1 zero, 2 all ones, 3 signed minimum)
    int kind_a [6] = '{0, 1, 2, 3, 3, 0};
    int kind_b [6] = '{0, 0, 2, 2, 3, 3};

    `include "tb_v_unit_model.svh"

    v_unit i_dut (
        .valu_clk (valu_clk), .arst_n (arst_n), .start (start),
        .op (op), .sew (sew), .lmul (lmul), .lanes (lanes),
        .op_a_1 (a_in[0]), .op_a_2 (a_in[1]), .op_a_3 (a_in[2]), .op_a_4 (a_in[3]),
        .op_b_1 (b_in[0]), .op_b_2 (b_in[1]), .op_b_3 (b_in[2]), .op_b_4 (b_in[3]),
        .res_1 (res_w[0]), .res_2 (res_w[1]), .res_3 (res_w[2]), .res_4 (res_w[3]),
        .busy (busy), .done (done), .err (err)
    );

    always #20 valu_clk = ~valu_clk;

    ////////////////////////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_results(input string what);
        for (int k = 0; k < `NUM_GROUPS; k++) begin
            checks++;
            if (res_w[k] !== exp_res[k]) begin
                errors++;
                $display("FAIL %0t ns: %s res_%0d is %h, expected %h",
                         $time, what, k + 1, res_w[k], exp_res[k]);
            end
        end
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("Timed out waiting for %s at %0t ns", what, $time);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Regression failed");
        $finish;
    endtask

    // Compare process checking every done
    always @(negedge valu_clk) begin
        if (arst_n && done) begin
            check_results("at done");
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic vreg_t fill_reg(input int kind, input sew_code_t s);
        vreg_t r;
        case (kind)
            0: r = {$urandom, $urandom, $urandom, $urandom};
            1: r = '0;
            2: r = '1;
            default: begin
                r = '0;
                // Only the top bit of each element set
                for (int e = 0; e < `VLEN_BITS; e += (8 << s)) begin
                    r[e + (8 << s) - 1] = 1'b1;
                end
            end
        endcase
        return r;
    endfunction

    task automatic random_operands();
        for (int k = 0; k < `NUM_GROUPS; k++) begin
            a_in[k] = fill_reg(0, 2);
            b_in[k] = fill_reg(0, 2);
        end
    endtask

    task automatic set_expected(input vop_e f, input sew_code_t s, input lmul_code_t m);
        for (int k = 0; k < `NUM_GROUPS; k++) begin
            exp_res[k] = expected_reg(k, f, s, m, a_in[k], b_in[k]);
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic pulse_start(input vop_e f, input sew_code_t s, input lmul_code_t m,
                               input lanes_code_t n);
        op    = f;
        sew   = s;
        lmul  = m;
        lanes = n;
        start = 1'b1;
        @(negedge valu_clk);
        start = 1'b0;
    endtask

    // Cycles counted from the start edge
    task automatic wait_done(input int elapsed, output int lat);
        lat = elapsed;
        while (!done) begin
            if (lat >= 40) begin
                timeout_abort("done");
            end
            @(negedge valu_clk);
            lat++;
        end
    endtask

    task automatic run_instr(input vop_e f, input sew_code_t s, input lmul_code_t m,
                             input lanes_code_t n);
        int lat;
        set_expected(f, s, m);
        pulse_start(f, s, m, n);
        check_value("busy after start", busy, 1);
        wait_done(1, lat);
        check_value("start to done cycles", lat, pass_count(m, n) + 3);
        @(negedge valu_clk);
        check_value("busy after done", busy, 0);
        check_value("done after its pulse", done, 0);
    endtask

    task automatic check_reject(input vop_e f, input sew_code_t s, input lmul_code_t m,
                                input lanes_code_t n);
        random_operands();
        pulse_start(f, s, m, n);
        check_value("err after reserved code", err, 1);
        check_value("busy after reserved code", busy, 0);
        for (int c = 0; c < 8; c++) begin
            @(negedge valu_clk);
            check_value("err after its pulse", err, 0);
            check_value("busy after reject", busy, 0);
            check_value("done after reject", done, 0);
        end
        check_results("after reject");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int lat;
        valu_clk   = 1'b0;
        arst_n     = 1'b0;
        start      = 1'b0;
        op         = OP_ADD;
        sew        = '0;
        lmul       = '0;
        lanes      = '0;
        checks     = 0;
        errors     = 0;
        for (int k = 0; k < `NUM_GROUPS; k++) begin
            a_in[k]    = '0;
            b_in[k]    = '0;
            exp_res[k] = '0;
        end
        void'($urandom(32'he3c5_d301));
        for (int c = 0; c < 10; c++) begin
            @(negedge valu_clk);
        end
        arst_n = 1'b1;

        // Reset values
        check_value("busy after reset", busy, 0);
        check_value("done after reset", done, 0);
        check_value("err after reset", err, 0);
        check_results("after reset");
        @(negedge valu_clk);

        // Every op at every SEW on a full register group in one pass
        for (int o = 0; o <= `OP_CODE_MAX; o++) begin
            for (int s = 0; s <= `SEW_CODE_MAX; s++) begin
                for (int t = 0; t < 6; t++) begin
                    for (int k = 0; k < `NUM_GROUPS; k++) begin
                        a_in[k] = fill_reg(kind_a[t], sew_code_t'(s));
                        b_in[k] = fill_reg(kind_b[t], sew_code_t'(s));
                    end
                    run_instr(vop_e'(o), sew_code_t'(s), 2'd2, 2'd2);
                end
            end
        end

        // Each group size against each lane count
        // A full group first fills all registers
        for (int m = 0; m <= `LMUL_CODE_MAX; m++) begin
            for (int n = 0; n <= `LANES_CODE_MAX; n++) begin
                random_operands();
                run_instr(vop_e'($urandom_range(11, 0)), 3'd2, 2'd2, 2'd2);
                random_operands();
                run_instr(vop_e'($urandom_range(11, 0)), sew_code_t'($urandom_range(2, 0)),
                          lmul_code_t'(m), lanes_code_t'(n));
            end
        end

        // Reserved codes
        for (int s = 3; s < 8; s++) begin
            check_reject(OP_ADD, sew_code_t'(s), 2'd0, 2'd0);
        end
        check_reject(OP_XOR, 3'd1, 2'd3, 2'd0);
        check_reject(OP_SUB, 3'd0, 2'd1, 2'd3);
        for (int o = 12; o < 16; o++) begin
            check_reject(vop_e'(o), 3'd2, 2'd2, 2'd2);
        end

        // Starts arriving while a four-pass instruction is busy
        random_operands();
        set_expected(OP_MULH, 3'd1, 2'd2);
        pulse_start(OP_MULH, 3'd1, 2'd2, 2'd0);
        check_value("busy after start", busy, 1);
        random_operands();
        pulse_start(OP_ADD, 3'd0, 2'd0, 2'd2);
        pulse_start(OP_ADD, 3'd5, 2'd0, 2'd0);
        check_value("err on start while busy", err, 0);
        wait_done(3, lat);
        check_value("start to done cycles", lat, pass_count(2'd2, 2'd0) + 3);
        for (int c = 0; c < 10; c++) begin
            @(negedge valu_clk);
            check_value("done after busy start", done, 0);
        end

        // Back-to-back instructions issued right after busy falls
        for (int i = 0; i < 8; i++) begin
            random_operands();
            run_instr(vop_e'($urandom_range(11, 0)), sew_code_t'($urandom_range(2, 0)),
                      lmul_code_t'($urandom_range(2, 0)), lanes_code_t'($urandom_range(2, 0)));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== v_unit.f ====
+incdir+hdl
+incdir+tb
hdl/valu_pkg.sv
hdl/v_alu.sv
hdl/v_mul.sv
hdl/v_issue.sv
hdl/v_lanes.sv
hdl/v_unit.sv
tb/tb_v_unit.sv

// ==== Bender.yml ====
package:
  name: v_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/valu_pkg.sv
      - hdl/v_alu.sv
      - hdl/v_mul.sv
      - hdl/v_issue.sv
      - hdl/v_lanes.sv
      - hdl/v_unit.sv
  - target: test
    include_dirs:
      - hdl
      - tb
    files:
      - tb/tb_v_unit.sv
